/* hw/lsu_pkg.sv */
package lsu_pkg;

  // Datapath widths
  localparam int xlen   = 32;
  localparam int strb_w = xlen / 8;

  // Data memory depth in words, and the word index bits it decodes
  localparam int mem_words = 256;
  localparam int mem_aw    = $clog2(mem_words);

  typedef logic [xlen-1:0]   addr_t;
  typedef logic [xlen-1:0]   data_t;
  typedef logic [strb_w-1:0] strb_t;

  // Extra cycles the memory takes to finish a data phase
  typedef logic [1:0] wait_t;

  // Configuration register index
  typedef logic [1:0] cfg_addr_t;

  localparam cfg_addr_t cfg_wait_idx  = 2'd0;
  localparam cfg_addr_t cfg_limit_idx = 2'd1;

  // Operation handed over by the execute stage
  typedef enum logic [1:0] {
    no_lsu,
    lsu_load,
    lsu_store
  } lsu_op_e;

  // Access width, with the unsigned load variants
  typedef enum logic [2:0] {
    lsu_b,
    lsu_h,
    lsu_w,
    lsu_bu,
    lsu_hu
  } lsu_w_e;

  // Response codes on the core data bus
  typedef enum logic [1:0] {
    cb_okay,
    cb_slverr
  } cb_resp_e;

endpackage

/* hw/cb_if.sv */
interface cb_if;

  // Read address channel
  lsu_pkg::addr_t    rd_addr;
  logic              rd_addr_valid;
  logic              rd_addr_ready;

  // Read data channel
  lsu_pkg::data_t    rd_data;
  lsu_pkg::cb_resp_e rd_resp;
  logic              rd_valid;
  logic              rd_ready;

  // Write address channel
  lsu_pkg::addr_t    wr_addr;
  logic              wr_addr_valid;
  logic              wr_addr_ready;

  // Write data channel
  lsu_pkg::data_t    wr_data;
  lsu_pkg::strb_t    wr_strobe;
  logic              wr_data_valid;
  logic              wr_data_ready;

  // Write response channel
  lsu_pkg::cb_resp_e wr_resp;
  logic              wr_resp_valid;
  logic              wr_resp_ready;

  modport master (
    output rd_addr, rd_addr_valid,
    input  rd_addr_ready,
    input  rd_data, rd_resp, rd_valid,
    output rd_ready,
    output wr_addr, wr_addr_valid,
    input  wr_addr_ready,
    output wr_data, wr_strobe, wr_data_valid,
    input  wr_data_ready,
    input  wr_resp, wr_resp_valid,
    output wr_resp_ready
  );

  modport slave (
    input  rd_addr, rd_addr_valid,
    output rd_addr_ready,
    output rd_data, rd_resp, rd_valid,
    input  rd_ready,
    input  wr_addr, wr_addr_valid,
    output wr_addr_ready,
    input  wr_data, wr_strobe, wr_data_valid,
    output wr_data_ready,
    output wr_resp, wr_resp_valid,
    input  wr_resp_ready
  );

endinterface

/* hw/lsu.sv */
module lsu (
  input  logic              clk,
  input  logic              arst_n_i,
  // Execute stage operation
  input  lsu_pkg::lsu_op_e  op_type_i,
  input  lsu_pkg::lsu_w_e   op_width_i,
  input  lsu_pkg::addr_t    op_addr_i,
  input  lsu_pkg::data_t    op_wdata_i,
  output logic              stall_o,
  // Write-back side
  output lsu_pkg::lsu_op_e  wb_op_o,
  output lsu_pkg::data_t    wb_rdata_o,
  output logic              txn_error_o,
  // Core data bus
  cb_if.master              cb
);

  // Operation in the data phase
  lsu_pkg::lsu_op_e op_q;
  lsu_pkg::lsu_w_e  width_q;
  logic [1:0]       off_q;
  lsu_pkg::data_t   wdata_q;

  logic new_txn;
  logic rd_txn;
  logic req;
  logic wr_dp;
  logic data_done;
  logic bp_addr;
  logic bp_data;
  logic rd_err;
  logic wr_err;

  // Lane mask for the access width, moved up to the byte offset
  function automatic lsu_pkg::strb_t lane_mask(lsu_pkg::lsu_w_e width, logic [1:0] off);
    lsu_pkg::strb_t mask;
    case (width)
      lsu_pkg::lsu_b, lsu_pkg::lsu_bu: mask = 4'b0001;
      lsu_pkg::lsu_h, lsu_pkg::lsu_hu: mask = 4'b0011;
      default:                         mask = 4'b1111;
    endcase
    return mask << off;
  endfunction

  // Bring the addressed bytes down to lane 0 and extend them
  function automatic lsu_pkg::data_t align_load(lsu_pkg::data_t word, lsu_pkg::lsu_w_e width,
                                                logic [1:0] off);
    lsu_pkg::data_t shifted;
    lsu_pkg::data_t res;
    shifted = word >> {off, 3'b000};
    case (width)
      lsu_pkg::lsu_b:  res = {{24{shifted[7]}}, shifted[7:0]};
      lsu_pkg::lsu_h:  res = {{16{shifted[15]}}, shifted[15:0]};
      lsu_pkg::lsu_bu: res = {24'h0, shifted[7:0]};
      lsu_pkg::lsu_hu: res = {16'h0, shifted[15:0]};
      default:         res = shifted;
    endcase
    return res;
  endfunction

  always_comb begin
    new_txn = (op_type_i != lsu_pkg::no_lsu);
    rd_txn  = (op_type_i == lsu_pkg::lsu_load);
    req     = (op_q != lsu_pkg::no_lsu);
    wr_dp   = (op_q == lsu_pkg::lsu_store);

    // Address phase, always word aligned
    cb.rd_addr       = {op_addr_i[lsu_pkg::xlen-1:2], 2'b00};
    cb.rd_addr_valid = rd_txn;
    cb.wr_addr       = {op_addr_i[lsu_pkg::xlen-1:2], 2'b00};
    cb.wr_addr_valid = (op_type_i == lsu_pkg::lsu_store);

    // Responses are always taken
    cb.rd_ready      = 1'b1;
    cb.wr_resp_ready = 1'b1;

    // Store data moved into its lanes, unused lanes cleared
    cb.wr_strobe     = wr_dp ? lane_mask(width_q, off_q) : '0;
    cb.wr_data       = wdata_q << {off_q, 3'b000};
    for (int i = 0; i < lsu_pkg::strb_w; i++) begin
      if (!cb.wr_strobe[i]) begin
        cb.wr_data[8*i +: 8] = 8'h00;
      end
    end
    cb.wr_data_valid = wr_dp;

    data_done = req && (wr_dp ? cb.wr_data_ready : cb.rd_valid);

    // Stall when either phase cannot move on
    bp_addr = new_txn && (rd_txn ? !cb.rd_addr_ready : !cb.wr_addr_ready);
    bp_data = req && !data_done;
    stall_o = bp_addr || bp_data;

    rd_err      = !wr_dp && cb.rd_valid && (cb.rd_resp != lsu_pkg::cb_okay);
    wr_err      = wr_dp && cb.wr_data_ready && cb.wr_resp_valid &&
                  (cb.wr_resp != lsu_pkg::cb_okay);
    txn_error_o = req && (rd_err || wr_err);

    wb_op_o    = op_q;
    wb_rdata_o = (op_q == lsu_pkg::lsu_load) ? align_load(cb.rd_data, width_q, off_q) : '0;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q <= lsu_pkg::no_lsu;
    end else if (!stall_o) begin
      op_q <= op_type_i;
    end else if (data_done) begin
      // Data phase finished but the next address waits
      op_q <= lsu_pkg::no_lsu;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_o) begin
      width_q <= op_width_i;
      off_q   <= op_addr_i[1:0];
      wdata_q <= op_wdata_i;
    end
  end

endmodule

/* hw/data_ram.sv */
module data_ram (
  input  logic           clk,
  input  logic           arst_n_i,
  input  lsu_pkg::wait_t wait_states_i,
  // Word index, accesses at or above it fail
  input  lsu_pkg::addr_t addr_limit_i,
  cb_if.slave            cb
);

  lsu_pkg::data_t mem [lsu_pkg::mem_words];

  // Pending transfer
  logic                      pend_q;
  logic                      wr_q;
  logic                      err_q;
  lsu_pkg::wait_t            cnt_q;
  logic [lsu_pkg::mem_aw-1:0] idx_q;

  logic              ready_phase;
  logic              complete;
  logic              slot_free;
  logic              rd_acc;
  logic              wr_acc;
  lsu_pkg::addr_t    acc_addr;
  lsu_pkg::addr_t    acc_word;
  lsu_pkg::cb_resp_e resp;

  always_comb begin
    ready_phase = pend_q && (cnt_q >= wait_states_i);
    complete    = ready_phase &&
                  (wr_q ? (cb.wr_data_valid && cb.wr_resp_ready) : cb.rd_ready);

    // New address accepted when idle or in the completing cycle
    slot_free        = !pend_q || complete;
    cb.wr_addr_ready = slot_free;
    cb.rd_addr_ready = slot_free && !cb.wr_addr_valid;

    wr_acc   = cb.wr_addr_valid && cb.wr_addr_ready;
    rd_acc   = cb.rd_addr_valid && cb.rd_addr_ready;
    acc_addr = wr_acc ? cb.wr_addr : cb.rd_addr;
    acc_word = {2'b00, acc_addr[lsu_pkg::xlen-1:2]};

    resp = err_q ? lsu_pkg::cb_slverr : lsu_pkg::cb_okay;

    cb.rd_valid = ready_phase && !wr_q;
    cb.rd_resp  = resp;
    cb.rd_data  = (cb.rd_valid && !err_q) ? mem[idx_q] : '0;

    cb.wr_data_ready = ready_phase && wr_q;
    cb.wr_resp_valid = ready_phase && wr_q;
    cb.wr_resp       = resp;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q <= 1'b0;
      wr_q   <= 1'b0;
      err_q  <= 1'b0;
      cnt_q  <= '0;
    end else if (rd_acc || wr_acc) begin
      pend_q <= 1'b1;
      wr_q   <= wr_acc;
      err_q  <= (acc_word >= addr_limit_i);
      cnt_q  <= '0;
    end else if (complete) begin
      pend_q <= 1'b0;
    end else if (pend_q && !ready_phase) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc || wr_acc) begin
      idx_q <= acc_addr[2 +: lsu_pkg::mem_aw];
    end
  end

  // Contents start cleared, writes land at the completing edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < lsu_pkg::mem_words; i++) begin
        mem[i] <= '0;
      end
    end else if (complete && wr_q && !err_q) begin
      for (int l = 0; l < lsu_pkg::strb_w; l++) begin
        if (cb.wr_strobe[l]) begin
          mem[idx_q][8*l +: 8] <= cb.wr_data[8*l +: 8];
        end
      end
    end
  end

endmodule

/* hw/mem_cfg_regs.sv */
module mem_cfg_regs (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               cfg_we_i,
  input  lsu_pkg::cfg_addr_t cfg_addr_i,
  input  lsu_pkg::data_t     cfg_wdata_i,
  output lsu_pkg::wait_t     wait_states_o,
  output lsu_pkg::addr_t     addr_limit_o
);

  localparam lsu_pkg::addr_t max_limit = lsu_pkg::addr_t'(lsu_pkg::mem_words);

  lsu_pkg::wait_t wait_q;
  lsu_pkg::addr_t limit_q;
  lsu_pkg::addr_t limit_nxt;

  // Limit never goes past the memory depth
  always_comb begin
    if (cfg_wdata_i > max_limit) begin
      limit_nxt = max_limit;
    end else begin
      limit_nxt = cfg_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wait_q  <= '0;
      limit_q <= max_limit;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        lsu_pkg::cfg_wait_idx:  wait_q  <= cfg_wdata_i[1:0];
        lsu_pkg::cfg_limit_idx: limit_q <= limit_nxt;
        // Other indices have no register
        default: ;
      endcase
    end
  end

  assign wait_states_o = wait_q;
  assign addr_limit_o  = limit_q;

endmodule

/* hw/lsu_subsys_top.sv */
module lsu_subsys_top (
  input  logic               clk,
  input  logic               arst_n_i,
  // Execute stage operation
  input  lsu_pkg::lsu_op_e   op_type_i,
  input  lsu_pkg::lsu_w_e    op_width_i,
  input  lsu_pkg::addr_t     op_addr_i,
  input  lsu_pkg::data_t     op_wdata_i,
  // Configuration port
  input  logic               cfg_we_i,
  input  lsu_pkg::cfg_addr_t cfg_addr_i,
  input  lsu_pkg::data_t     cfg_wdata_i,
  // Results
  output logic               stall_o,
  output lsu_pkg::lsu_op_e   wb_op_o,
  output lsu_pkg::data_t     wb_rdata_o,
  output logic               txn_error_o
);

  lsu_pkg::wait_t wait_states;
  lsu_pkg::addr_t addr_limit;

  cb_if data_cb ();

  lsu u_lsu (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .op_type_i   (op_type_i),
    .op_width_i  (op_width_i),
    .op_addr_i   (op_addr_i),
    .op_wdata_i  (op_wdata_i),
    .stall_o     (stall_o),
    .wb_op_o     (wb_op_o),
    .wb_rdata_o  (wb_rdata_o),
    .txn_error_o (txn_error_o),
    .cb          (data_cb.master)
  );

  data_ram u_data_ram (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .wait_states_i (wait_states),
    .addr_limit_i  (addr_limit),
    .cb            (data_cb.slave)
  );

  mem_cfg_regs u_mem_cfg_regs (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_addr_i    (cfg_addr_i),
    .cfg_wdata_i   (cfg_wdata_i),
    .wait_states_o (wait_states),
    .addr_limit_o  (addr_limit)
  );

endmodule

/* test/lsu_subsys_checker.sv */
module lsu_subsys_checker (
  input logic           clk,
  input logic           arst_n_i,
  input logic           stall_o,
  input logic           txn_error_o,
  input logic           rd_addr_valid,
  input logic           rd_addr_ready,
  input lsu_pkg::addr_t rd_addr,
  input logic           wr_addr_valid,
  input logic           wr_addr_ready,
  input lsu_pkg::addr_t wr_addr,
  input logic           wr_data_valid,
  input logic           wr_data_ready,
  input lsu_pkg::data_t wr_data,
  input lsu_pkg::strb_t wr_strobe
);
  timeunit 1ns;
  timeprecision 100ps;

  // Number of failed assertions
  int fail_cnt = 0;

  // Valid and payload hold until the ready edge
  rd_addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    rd_addr_valid && !rd_addr_ready |=> rd_addr_valid && $stable(rd_addr))
    else begin
      $error("read address dropped before ready");
      fail_cnt++;
    end

  wr_addr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_addr_valid && !wr_addr_ready |=> wr_addr_valid && $stable(wr_addr))
    else begin
      $error("write address dropped before ready");
      fail_cnt++;
    end

  wr_data_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_data_valid && !wr_data_ready |=> wr_data_valid && $stable(wr_data))
    else begin
      $error("write data dropped before ready");
      fail_cnt++;
    end

  // Quiet outputs while in reset and on the first cycle out of it
  reset_quiet: assert property (@(posedge clk)
    (!arst_n_i || $rose(arst_n_i)) |-> !stall_o && !txn_error_o)
    else begin
      $error("stall_o or txn_error_o high around reset");
      fail_cnt++;
    end

  strobe_nonzero: assert property (@(posedge clk) disable iff (!arst_n_i)
    wr_data_valid |-> wr_strobe != '0)
    else begin
      $error("write data beat with empty strobe");
      fail_cnt++;
    end

endmodule

bind lsu_subsys_top lsu_subsys_checker u_checker (
  .clk           (clk),
  .arst_n_i      (arst_n_i),
  .stall_o       (stall_o),
  .txn_error_o   (txn_error_o),
  .rd_addr_valid (data_cb.rd_addr_valid),
  .rd_addr_ready (data_cb.rd_addr_ready),
  .rd_addr       (data_cb.rd_addr),
  .wr_addr_valid (data_cb.wr_addr_valid),
  .wr_addr_ready (data_cb.wr_addr_ready),
  .wr_addr       (data_cb.wr_addr),
  .wr_data_valid (data_cb.wr_data_valid),
  .wr_data_ready (data_cb.wr_data_ready),
  .wr_data       (data_cb.wr_data),
  .wr_strobe     (data_cb.wr_strobe)
);

/* test/tb_lsu_subsys.sv */
module tb_lsu_subsys;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_rows = 128;
  localparam int max_wait = 20;

  logic               clk;
  logic               arst_n_i;
  lsu_pkg::lsu_op_e   op_type_i;
  lsu_pkg::lsu_w_e    op_width_i;
  lsu_pkg::addr_t     op_addr_i;
  lsu_pkg::data_t     op_wdata_i;
  logic               cfg_we_i;
  lsu_pkg::cfg_addr_t cfg_addr_i;
  lsu_pkg::data_t     cfg_wdata_i;
  logic               stall_o;
  lsu_pkg::lsu_op_e   wb_op_o;
  lsu_pkg::data_t     wb_rdata_o;
  logic               txn_error_o;

  // Stimulus table with expected results
  string            row_name      [max_rows];
  int               row_ws        [max_rows];
  int               row_lim       [max_rows];
  lsu_pkg::lsu_op_e row_op        [max_rows];
  lsu_pkg::lsu_w_e  row_width     [max_rows];
  lsu_pkg::addr_t   row_addr      [max_rows];
  lsu_pkg::data_t   row_wdata     [max_rows];
  lsu_pkg::data_t   row_exp_rdata [max_rows];
  logic             row_exp_err   [max_rows];
  int               n_rows;

  // Reference memory advanced as rows are added
  lsu_pkg::data_t model_mem [lsu_pkg::mem_words];

  int mismatches;
  int timeouts;
  int checks;
  int pend_row;
  int cur_ws;
  int cur_lim;

  lsu_subsys_top UUT (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .op_type_i   (op_type_i),
    .op_width_i  (op_width_i),
    .op_addr_i   (op_addr_i),
    .op_wdata_i  (op_wdata_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .stall_o     (stall_o),
    .wb_op_o     (wb_op_o),
    .wb_rdata_o  (wb_rdata_o),
    .txn_error_o (txn_error_o)
  );

  always #50 clk = ~clk;

  // Append one operation and work out its expected result
  task automatic add_row(input string name, input int ws, input int lim,
                         input lsu_pkg::lsu_op_e op, input lsu_pkg::lsu_w_e w,
                         input lsu_pkg::addr_t addr, input lsu_pkg::data_t wdata);
    int             idx;
    int             off;
    int             nbytes;
    logic           err;
    lsu_pkg::data_t res;
    idx    = int'(addr >> 2);
    off    = int'(addr[1:0]);
    nbytes = (w == lsu_pkg::lsu_w) ? 4 : ((w == lsu_pkg::lsu_h || w == lsu_pkg::lsu_hu) ? 2 : 1);
    err    = (idx >= lim);
    res    = '0;
    if (op == lsu_pkg::lsu_store && !err) begin
      for (int k = 0; k < nbytes; k++) begin
        model_mem[idx][8*(off+k) +: 8] = wdata[8*k +: 8];
      end
    end
    if (op == lsu_pkg::lsu_load && !err) begin
      for (int k = 0; k < nbytes; k++) begin
        res[8*k +: 8] = model_mem[idx][8*(off+k) +: 8];
      end
      // Signed loads copy the top loaded bit upward
      if ((w == lsu_pkg::lsu_b || w == lsu_pkg::lsu_h) && res[8*nbytes-1]) begin
        for (int k = nbytes; k < 4; k++) begin
          res[8*k +: 8] = 8'hff;
        end
      end
    end
    row_name[n_rows]      = name;
    row_ws[n_rows]        = ws;
    row_lim[n_rows]       = lim;
    row_op[n_rows]        = op;
    row_width[n_rows]     = w;
    row_addr[n_rows]      = addr;
    row_wdata[n_rows]     = wdata;
    row_exp_rdata[n_rows] = res;
    row_exp_err[n_rows]   = err;
    n_rows++;
  endtask

  task automatic build_table;
    lsu_pkg::addr_t a;
    lsu_pkg::data_t rnd [2];
    lsu_pkg::data_t v;
    add_row("word_st", 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, 32'h10, 32'hcafe_f00d);
    add_row("word_ld", 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, 32'h10, '0);
    // Narrow stores over a filled word with junk in the upper data bits
    for (int off = 0; off < 4; off++) begin
      a = 32'h40 + 4 * off;
      add_row($sformatf("sb_fill%0d", off), 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, a,
              32'ha5a5_a5a5);
      add_row($sformatf("sb_off%0d", off), 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_b,
              a + off, 32'hdead_be00 | off);
      add_row($sformatf("sb_chk%0d", off), 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, a, '0);
    end
    for (int off = 0; off < 4; off += 2) begin
      a = 32'h60 + 2 * off;
      add_row($sformatf("sh_fill%0d", off), 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, a,
              32'h5a5a_5a5a);
      add_row($sformatf("sh_off%0d", off), 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_h,
              a + off, 32'hbeef_0000 | (32'h1234 + off));
      add_row($sformatf("sh_chk%0d", off), 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, a, '0);
    end
    // One word with every byte negative and one with none
    rnd[0] = $urandom() | 32'h8080_8080;
    rnd[1] = $urandom() & 32'h7f7f_7f7f;
    for (int k = 0; k < 2; k++) begin
      a = 32'h80 + 4 * k;
      add_row($sformatf("rnd_st%0d", k), 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, a, rnd[k]);
      for (int off = 0; off < 4; off++) begin
        add_row($sformatf("lb_%0d_%0d", k, off), 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_b,
                a + off, '0);
        add_row($sformatf("lbu_%0d_%0d", k, off), 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_bu,
                a + off, '0);
        if (off % 2 == 0) begin
          add_row($sformatf("lh_%0d_%0d", k, off), 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_h,
                  a + off, '0);
          add_row($sformatf("lhu_%0d_%0d", k, off), 0, 256, lsu_pkg::lsu_load,
                  lsu_pkg::lsu_hu, a + off, '0);
        end
      end
    end
    // Back-to-back traffic under back-pressure
    for (int ws = 1; ws < 4; ws++) begin
      a = 32'ha0 + 8 * ws;
      v = $urandom();
      add_row($sformatf("ws%0d_st", ws), ws, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, a, v);
      add_row($sformatf("ws%0d_ld", ws), ws, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, a, '0);
      add_row($sformatf("ws%0d_sh", ws), ws, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_h, a + 2,
              $urandom());
      add_row($sformatf("ws%0d_lbu", ws), ws, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_bu, a + 3,
              '0);
      add_row($sformatf("ws%0d_chk", ws), ws, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, a, '0);
    end
    // Error region from word 56 up
    add_row("lim_pre", 0, 256, lsu_pkg::lsu_store, lsu_pkg::lsu_w, 32'he0, 32'h5a5a_1234);
    add_row("lim_st", 0, 56, lsu_pkg::lsu_store, lsu_pkg::lsu_w, 32'he0, 32'hffff_ffff);
    add_row("lim_ld", 0, 56, lsu_pkg::lsu_load, lsu_pkg::lsu_w, 32'he0, '0);
    add_row("lim_sb", 0, 56, lsu_pkg::lsu_store, lsu_pkg::lsu_b, 32'hf1, 32'h0000_0077);
    add_row("below_st", 0, 56, lsu_pkg::lsu_store, lsu_pkg::lsu_w, 32'hdc, 32'h600d_600d);
    add_row("below_ld", 0, 56, lsu_pkg::lsu_load, lsu_pkg::lsu_w, 32'hdc, '0);
    add_row("lim_post", 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, 32'he0, '0);
    add_row("lim_sb_post", 0, 256, lsu_pkg::lsu_load, lsu_pkg::lsu_w, 32'hf0, '0);
  endtask

  task automatic check_row(input int r, input int waited);
    checks++;
    if (wb_op_o !== row_op[r]) begin
      $display("mismatch %s wb_op_o expected %s actual %s", row_name[r], row_op[r].name(),
               wb_op_o.name());
      mismatches++;
    end
    if (txn_error_o !== row_exp_err[r]) begin
      $display("mismatch %s txn_error_o expected %0b actual %0b", row_name[r],
               row_exp_err[r], txn_error_o);
      mismatches++;
    end
    if (row_op[r] == lsu_pkg::lsu_load && wb_rdata_o !== row_exp_rdata[r]) begin
      $display("mismatch %s wb_rdata_o expected %08h actual %08h", row_name[r],
               row_exp_rdata[r], wb_rdata_o);
      mismatches++;
    end
    if (waited != row_ws[r]) begin
      $display("mismatch %s latency expected %0d actual %0d", row_name[r], row_ws[r], waited);
      mismatches++;
    end
  endtask

  // The data phase in flight is complete once stall_o is low
  task automatic advance(input int next_row);
    int waited;
    waited = 0;
    @(negedge clk);
    while (stall_o && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (stall_o) begin
      $display("timeout: stall_o stayed high for %0d cycles", max_wait);
      timeouts++;
    end else begin
      if (pend_row >= 0) begin
        check_row(pend_row, waited);
      end
      pend_row = next_row;
    end
  endtask

  task automatic issue(input int r);
    @(posedge clk);
    op_type_i  <= row_op[r];
    op_width_i <= row_width[r];
    op_addr_i  <= row_addr[r];
    op_wdata_i <= row_wdata[r];
    advance(r);
  endtask

  task automatic drain;
    @(posedge clk);
    op_type_i <= lsu_pkg::no_lsu;
    advance(-1);
  endtask

  task automatic write_cfg(input lsu_pkg::cfg_addr_t idx, input int value);
    @(posedge clk);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= idx;
    cfg_wdata_i <= lsu_pkg::data_t'(value);
    @(posedge clk);
    cfg_we_i    <= 1'b0;
  endtask

  initial begin
    void'($urandom(34195));
    clk         = 1'b0;
    arst_n_i    = 1'b0;
    op_type_i   = lsu_pkg::no_lsu;
    op_width_i  = lsu_pkg::lsu_w;
    op_addr_i   = '0;
    op_wdata_i  = '0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    mismatches  = 0;
    timeouts    = 0;
    checks      = 0;
    pend_row    = -1;
    n_rows      = 0;
    // Reset values of the configuration registers
    cur_ws      = 0;
    cur_lim     = lsu_pkg::mem_words;
    for (int i = 0; i < lsu_pkg::mem_words; i++) begin
      model_mem[i] = '0;
    end
    build_table();

    repeat (16) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    if ({stall_o, txn_error_o, wb_op_o} !== {1'b0, 1'b0, lsu_pkg::no_lsu}) begin
      $display("mismatch reset {stall_o,txn_error_o,wb_op_o} expected %b actual %b",
               {1'b0, 1'b0, lsu_pkg::no_lsu}, {stall_o, txn_error_o, wb_op_o});
      mismatches++;
    end

    for (int i = 0; i < n_rows && timeouts == 0; i++) begin
      // Configuration only changes with the bus idle
      if (row_ws[i] != cur_ws || row_lim[i] != cur_lim) begin
        drain();
        write_cfg(lsu_pkg::cfg_wait_idx, row_ws[i]);
        write_cfg(lsu_pkg::cfg_limit_idx, row_lim[i]);
        cur_ws  = row_ws[i];
        cur_lim = row_lim[i];
      end
      issue(i);
    end
    if (timeouts == 0) begin
      drain();
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures, %0d checked",
             mismatches, timeouts, UUT.u_checker.fail_cnt, checks);
    if (mismatches == 0 && timeouts == 0 && UUT.u_checker.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
hw/lsu_pkg.sv
hw/cb_if.sv
hw/lsu.sv
hw/data_ram.sv
hw/mem_cfg_regs.sv
hw/lsu_subsys_top.sv
test/lsu_subsys_checker.sv
test/tb_lsu_subsys.sv

/* Bender.yml */
package:
  name: lsu_subsys

sources:
  - files:
      - hw/lsu_pkg.sv
      - hw/cb_if.sv
      - hw/lsu.sv
      - hw/data_ram.sv
      - hw/mem_cfg_regs.sv
      - hw/lsu_subsys_top.sv
  - target: test
    files:
      - test/lsu_subsys_checker.sv
      - test/tb_lsu_subsys.sv
